// ==== logic/hart_pkg.sv ====
package hart_pkg;

  // data and address width of the hart
  localparam int xlen_w = 32;
  // first fetch address after reset
  localparam logic [xlen_w-1:0] reset_pc = '0;
  // ebreak is the one system instruction the hart accepts, it halts the run
  localparam logic [xlen_w-1:0] ebreak_word = 32'h0010_0073;

  typedef logic [xlen_w-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // major opcodes, anything else retires as a trap
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // low three bits follow funct3, bit 3 is the funct7 alternate form
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SLL    = 4'b0001,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_XOR    = 4'b0100,
    ALU_SRL    = 4'b0101,
    ALU_OR     = 4'b0110,
    ALU_AND    = 4'b0111,
    ALU_SUB    = 4'b1000,
    ALU_SRA    = 4'b1101,
    ALU_PASS_B = 4'b1111
  } alu_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wb_sel_e;

  // source of an execute operand
  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

  // the six instruction format views of one word
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2, rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_addr_t  rs2, rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    jal;
    logic    jalr;
    logic    use_rs1;
    logic    use_rs2;
    logic    alu_src_imm;
    logic    alu_src_pc;
    alu_op_e alu_op;
    wb_sel_e wb_sel;
    logic    trap;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_u inst;
  } if_id_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_u inst;
    ctrl_t ctrl;
    word_t rs1_data;
    word_t rs2_data;
    word_t imm;
  } id_ex_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t next_pc;
    inst_u inst;
    ctrl_t ctrl;
    word_t alu_result;
    word_t store_data;
    word_t pc_plus4;
    word_t imm;
  } ex_mem_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t next_pc;
    inst_u inst;
    ctrl_t ctrl;
    word_t rd_data;
  } mem_wb_t;

  typedef struct packed {
    logic      valid;
    word_t     inst;
    logic      trap;
    logic      halt;
    word_t     pc;
    word_t     next_pc;
    reg_addr_t rd_waddr;
    word_t     rd_wdata;
  } retire_t;

endpackage

// ==== logic/hart_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module hart_fetch (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_stall,
  input  logic                     i_flush,
  input  logic                     i_redirect,
  input  hart_pkg::word_t          i_target,
  output hart_pkg::word_t          o_imem_raddr,
  input  hart_pkg::word_t          i_imem_rdata,
  output hart_pkg::if_id_t         o_if_id
);

  hart_pkg::word_t pc_q;

  // instruction memory answers in the same cycle
  assign o_imem_raddr = pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q          <= hart_pkg::reset_pc;
      o_if_id.valid <= 1'b0;
    end else begin
      // a redirect from execute beats a load-use stall
      if (i_redirect) begin
        pc_q <= i_target;
      end else if (!i_stall) begin
        pc_q <= pc_q + 32'd4;
      end
      // the word fetched this cycle is younger than the taken transfer
      if (i_flush) begin
        o_if_id.valid <= 1'b0;
      end else if (!i_stall) begin
        o_if_id.valid <= 1'b1;
        o_if_id.pc    <= pc_q;
        o_if_id.inst  <= i_imem_rdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/hart_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module hart_regfile (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::reg_addr_t i_rs1_addr,
  input  hart_pkg::reg_addr_t i_rs2_addr,
  output hart_pkg::word_t     o_rs1_data,
  output hart_pkg::word_t     o_rs2_data,
  input  logic                i_rd_wen,
  input  hart_pkg::reg_addr_t i_rd_addr,
  input  hart_pkg::word_t     i_rd_wdata
);

  // x0 has no storage
  hart_pkg::word_t regs [1:31];

  // a read of the register written this cycle sees the new value
  function automatic hart_pkg::word_t read_port(input hart_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (i_rd_wen && i_rd_addr == addr) begin
      return i_rd_wdata;
    end
    return regs[addr];
  endfunction

  assign o_rs1_data = read_port(i_rs1_addr);
  assign o_rs2_data = read_port(i_rs2_addr);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen) begin
      regs[i_rd_addr] <= i_rd_wdata;
    end
  end

  // writeback drops rd == 0 before it reaches the register file
  a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rd_wen |-> i_rd_addr != '0)
    else $error("register file write enabled for x0");

endmodule

`default_nettype wire

// ==== logic/hart_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module hart_decode (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_stall,
  input  logic                i_flush,
  input  hart_pkg::if_id_t    i_if_id,
  input  logic                i_wb_wen,
  input  hart_pkg::reg_addr_t i_wb_addr,
  input  hart_pkg::word_t     i_wb_data,
  output hart_pkg::reg_addr_t o_rs1_addr,
  output hart_pkg::reg_addr_t o_rs2_addr,
  output hart_pkg::id_ex_t    o_id_ex
);

  hart_pkg::inst_u inst;
  hart_pkg::ctrl_t ctrl;
  hart_pkg::word_t imm;
  hart_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  hart_pkg::word_t rs1_data, rs2_data;
  logic [2:0]      f3;
  logic            alt;
  logic            bad;

  assign inst = i_if_id.inst;
  assign f3   = inst.r.funct3;

  // every immediate format, the opcode picks one below
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                  inst.b.imm4_1, 1'b0};
  assign imm_u = {inst.u.imm, 12'b0};
  assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                  inst.j.imm10_1, 1'b0};

  always_comb begin
    ctrl = '0;
    imm  = imm_i;
    alt  = 1'b0;
    bad  = 1'b0;
    case (inst.r.opcode)
      hart_pkg::LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = hart_pkg::ALU_PASS_B;
        ctrl.wb_sel      = hart_pkg::WB_IMM;
        imm              = imm_u;
      end
      hart_pkg::AUIPC: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_src_pc  = 1'b1;
        imm              = imm_u;
      end
      hart_pkg::JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
        ctrl.wb_sel    = hart_pkg::WB_PC4;
        imm            = imm_j;
      end
      hart_pkg::JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.use_rs1   = 1'b1;
        ctrl.wb_sel    = hart_pkg::WB_PC4;
      end
      hart_pkg::BRANCH: begin
        // funct3 010 and 011 are not branches
        bad          = (f3[2:1] == 2'b01);
        ctrl.branch  = 1'b1;
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
        imm          = imm_b;
      end
      hart_pkg::LOAD: begin
        // only lw survives
        bad              = (f3 != 3'b010);
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.use_rs1     = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb_sel      = hart_pkg::WB_MEM;
      end
      hart_pkg::STORE: begin
        bad              = (f3 != 3'b010);
        ctrl.mem_write   = 1'b1;
        ctrl.use_rs1     = 1'b1;
        ctrl.use_rs2     = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = imm_s;
      end
      hart_pkg::OP_IMM: begin
        // srai is the only immediate op with an alternate form
        alt              = (f3 == 3'b101) & inst.r.funct7[5];
        ctrl.reg_write   = 1'b1;
        ctrl.use_rs1     = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = hart_pkg::alu_op_e'({alt, f3});
      end
      hart_pkg::OP: begin
        alt            = (f3 == 3'b000 || f3 == 3'b101) & inst.r.funct7[5];
        ctrl.reg_write = 1'b1;
        ctrl.use_rs1   = 1'b1;
        ctrl.use_rs2   = 1'b1;
        ctrl.alu_op    = hart_pkg::alu_op_e'({alt, f3});
      end
      hart_pkg::SYSTEM: begin
        bad       = (inst != hart_pkg::ebreak_word);
        ctrl.halt = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    // a trap has no side effects at all, it only retires
    if (bad) begin
      ctrl      = '0;
      ctrl.trap = 1'b1;
    end
  end

  hart_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_addr (inst.r.rs1),
    .i_rs2_addr (inst.r.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_rd_wen   (i_wb_wen),
    .i_rd_addr  (i_wb_addr),
    .i_rd_wdata (i_wb_data)
  );

  // hazard unit only sees sources this instruction really reads
  assign o_rs1_addr = (i_if_id.valid && ctrl.use_rs1) ? inst.r.rs1 : '0;
  assign o_rs2_addr = (i_if_id.valid && ctrl.use_rs2) ? inst.r.rs2 : '0;

  always_ff @(posedge i_clk) begin
    // a stall or flush sends a bubble into execute
    if (i_rst || i_stall || i_flush) begin
      o_id_ex.valid <= 1'b0;
    end else begin
      o_id_ex.valid    <= i_if_id.valid;
      o_id_ex.pc       <= i_if_id.pc;
      o_id_ex.inst     <= inst;
      o_id_ex.ctrl     <= ctrl;
      o_id_ex.rs1_data <= rs1_data;
      o_id_ex.rs2_data <= rs2_data;
      o_id_ex.imm      <= imm;
    end
  end

  a_one_mem_op: assert property (@(posedge i_clk) disable iff (i_rst)
    o_id_ex.valid |-> !(o_id_ex.ctrl.mem_read && o_id_ex.ctrl.mem_write))
    else $error("load and store decoded for one instruction");

endmodule

`default_nettype wire

// ==== logic/hart_hazard.sv ====
`timescale 1ns/1ns
`default_nettype none

module hart_hazard (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::reg_addr_t i_rs1_addr,
  input  hart_pkg::reg_addr_t i_rs2_addr,
  input  hart_pkg::id_ex_t    i_id_ex,
  input  hart_pkg::ex_mem_t   i_ex_mem,
  input  hart_pkg::mem_wb_t   i_mem_wb,
  input  logic                i_redirect,
  output logic                o_stall,
  output logic                o_flush,
  output hart_pkg::fwd_sel_e  o_fwd_a_sel,
  output hart_pkg::fwd_sel_e  o_fwd_b_sel
);

  hart_pkg::reg_addr_t ex_rd;

  // the memory stage holds the younger result so it is checked last
  function automatic hart_pkg::fwd_sel_e pick(input hart_pkg::reg_addr_t src,
                                              input logic used);
    hart_pkg::fwd_sel_e sel;
    sel = hart_pkg::FWD_REG;
    if (used && src != '0) begin
      if (i_mem_wb.valid && i_mem_wb.ctrl.reg_write && i_mem_wb.inst.r.rd == src) begin
        sel = hart_pkg::FWD_WB;
      end
      if (i_ex_mem.valid && i_ex_mem.ctrl.reg_write && i_ex_mem.inst.r.rd == src) begin
        sel = hart_pkg::FWD_MEM;
      end
    end
    return sel;
  endfunction

  assign ex_rd = i_id_ex.inst.r.rd;

  // decode zeroes unused sources, so a nonzero match is a real dependence
  assign o_stall = i_id_ex.valid && i_id_ex.ctrl.mem_read && ex_rd != '0 &&
                   (ex_rd == i_rs1_addr || ex_rd == i_rs2_addr);

  assign o_flush = i_redirect;

  always_comb begin
    o_fwd_a_sel = pick(i_id_ex.inst.r.rs1, i_id_ex.ctrl.use_rs1);
    o_fwd_b_sel = pick(i_id_ex.inst.r.rs2, i_id_ex.ctrl.use_rs2);
  end

  // a flush empties decode, so nothing can ask for a stall right after it
  a_flush_then_no_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    o_flush |=> !o_stall)
    else $error("load-use stall raised on a flushed instruction");

endmodule

`default_nettype wire

// ==== logic/hart_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module hart_execute (
  input  logic               i_clk,
  input  logic               i_rst,
  input  hart_pkg::id_ex_t   i_id_ex,
  input  hart_pkg::fwd_sel_e i_fwd_a_sel,
  input  hart_pkg::fwd_sel_e i_fwd_b_sel,
  input  hart_pkg::word_t    i_mem_fwd,
  input  hart_pkg::word_t    i_wb_fwd,
  output logic               o_redirect,
  output hart_pkg::word_t    o_target,
  output hart_pkg::ex_mem_t  o_ex_mem
);

  hart_pkg::word_t rs1_val, rs2_val;
  hart_pkg::word_t alu_a, alu_b, alu_y;
  hart_pkg::word_t pc_plus4;
  logic [2:0]      f3;
  logic            cond;
  logic            taken;

  function automatic hart_pkg::word_t fwd(input hart_pkg::fwd_sel_e sel,
                                          input hart_pkg::word_t reg_val);
    case (sel)
      hart_pkg::FWD_MEM: return i_mem_fwd;
      hart_pkg::FWD_WB:  return i_wb_fwd;
      default:           return reg_val;
    endcase
  endfunction

  assign rs1_val = fwd(i_fwd_a_sel, i_id_ex.rs1_data);
  assign rs2_val = fwd(i_fwd_b_sel, i_id_ex.rs2_data);

  // auipc adds to the pc, every I, S and U form takes the immediate
  assign alu_a = i_id_ex.ctrl.alu_src_pc ? i_id_ex.pc : rs1_val;
  assign alu_b = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : rs2_val;

  always_comb begin
    case (i_id_ex.ctrl.alu_op)
      hart_pkg::ALU_SUB:    alu_y = alu_a - alu_b;
      hart_pkg::ALU_SLL:    alu_y = alu_a << alu_b[4:0];
      hart_pkg::ALU_SLT:    alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
      hart_pkg::ALU_SLTU:   alu_y = {31'b0, alu_a < alu_b};
      hart_pkg::ALU_XOR:    alu_y = alu_a ^ alu_b;
      hart_pkg::ALU_SRL:    alu_y = alu_a >> alu_b[4:0];
      hart_pkg::ALU_SRA:    alu_y = $signed(alu_a) >>> alu_b[4:0];
      hart_pkg::ALU_OR:     alu_y = alu_a | alu_b;
      hart_pkg::ALU_AND:    alu_y = alu_a & alu_b;
      hart_pkg::ALU_PASS_B: alu_y = alu_b;
      default:              alu_y = alu_a + alu_b;
    endcase
  end

  // funct3 bit 2 picks less-than over equal, bit 1 unsigned, bit 0 inverts
  assign f3 = i_id_ex.inst.b.funct3;
  always_comb begin
    if (!f3[2]) begin
      cond = (rs1_val == rs2_val);
    end else if (f3[1]) begin
      cond = (rs1_val < rs2_val);
    end else begin
      cond = ($signed(rs1_val) < $signed(rs2_val));
    end
    cond = cond ^ f3[0];
  end

  assign taken = i_id_ex.ctrl.jal | i_id_ex.ctrl.jalr | (i_id_ex.ctrl.branch & cond);
  assign o_redirect = i_id_ex.valid & taken;
  assign pc_plus4   = i_id_ex.pc + 32'd4;

  // jalr clears bit 0 of its sum
  assign o_target = i_id_ex.ctrl.jalr ? ((rs1_val + i_id_ex.imm) & ~32'd1)
                                      : (i_id_ex.pc + i_id_ex.imm);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ex_mem.valid <= 1'b0;
    end else begin
      o_ex_mem.valid      <= i_id_ex.valid;
      o_ex_mem.pc         <= i_id_ex.pc;
      o_ex_mem.next_pc    <= taken ? o_target : pc_plus4;
      o_ex_mem.inst       <= i_id_ex.inst;
      o_ex_mem.ctrl       <= i_id_ex.ctrl;
      o_ex_mem.alu_result <= alu_y;
      o_ex_mem.store_data <= rs2_val;
      o_ex_mem.pc_plus4   <= pc_plus4;
      o_ex_mem.imm        <= i_id_ex.imm;
    end
  end

endmodule

`default_nettype wire

// ==== logic/hart_memwb.sv ====
`timescale 1ns/1ns
`default_nettype none

module hart_memwb (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::ex_mem_t   i_ex_mem,
  output hart_pkg::word_t     o_dmem_addr,
  output logic                o_dmem_ren,
  output logic                o_dmem_wen,
  output hart_pkg::word_t     o_dmem_wdata,
  input  hart_pkg::word_t     i_dmem_rdata,
  output hart_pkg::word_t     o_mem_fwd,
  output hart_pkg::mem_wb_t   o_mem_wb,
  output logic                o_wb_wen,
  output hart_pkg::reg_addr_t o_wb_addr,
  output hart_pkg::word_t     o_wb_data,
  output hart_pkg::retire_t   o_retire
);

  hart_pkg::word_t rd_data;
  logic            halted_q;
  logic            stop;

  // once ebreak reaches writeback nothing younger may touch state
  assign stop = halted_q | (o_mem_wb.valid & o_mem_wb.ctrl.halt);

  assign o_dmem_addr  = i_ex_mem.alu_result;
  assign o_dmem_ren   = i_ex_mem.valid & i_ex_mem.ctrl.mem_read & ~stop;
  assign o_dmem_wen   = i_ex_mem.valid & i_ex_mem.ctrl.mem_write & ~stop;
  assign o_dmem_wdata = i_ex_mem.store_data;

  always_comb begin
    case (i_ex_mem.ctrl.wb_sel)
      hart_pkg::WB_MEM: rd_data = i_dmem_rdata;
      hart_pkg::WB_PC4: rd_data = i_ex_mem.pc_plus4;
      hart_pkg::WB_IMM: rd_data = i_ex_mem.imm;
      default:          rd_data = i_ex_mem.alu_result;
    endcase
  end

  // load data is already here since the data read is combinational
  assign o_mem_fwd = rd_data;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mem_wb.valid <= 1'b0;
      halted_q       <= 1'b0;
    end else begin
      o_mem_wb.valid   <= i_ex_mem.valid;
      o_mem_wb.pc      <= i_ex_mem.pc;
      o_mem_wb.next_pc <= i_ex_mem.next_pc;
      o_mem_wb.inst    <= i_ex_mem.inst;
      o_mem_wb.ctrl    <= i_ex_mem.ctrl;
      o_mem_wb.rd_data <= rd_data;
      halted_q         <= stop;
    end
  end

  assign o_wb_wen  = o_mem_wb.valid & o_mem_wb.ctrl.reg_write & ~halted_q &
                     (o_mem_wb.inst.r.rd != '0);
  assign o_wb_addr = o_mem_wb.inst.r.rd;
  assign o_wb_data = o_mem_wb.rd_data;

  // instructions that write nothing report rd and data as zero
  always_comb begin
    o_retire.valid    = o_mem_wb.valid & ~halted_q;
    o_retire.inst     = o_mem_wb.inst;
    o_retire.trap     = o_mem_wb.ctrl.trap;
    o_retire.halt     = o_mem_wb.ctrl.halt;
    o_retire.pc       = o_mem_wb.pc;
    o_retire.next_pc  = o_mem_wb.next_pc;
    o_retire.rd_waddr = o_wb_wen ? o_wb_addr : '0;
    o_retire.rd_wdata = o_wb_wen ? o_wb_data : '0;
  end

  a_dmem_one_op: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_dmem_ren && o_dmem_wen))
    else $error("data memory read and write in one cycle");

endmodule

`default_nettype wire

// ==== logic/hart.sv ====
`timescale 1ns/1ns
`default_nettype none

module hart (
  input  logic              i_clk,
  input  logic              i_rst,
  output hart_pkg::word_t   o_imem_raddr,
  input  hart_pkg::word_t   i_imem_rdata,
  output hart_pkg::word_t   o_dmem_addr,
  output logic              o_dmem_ren,
  output logic              o_dmem_wen,
  output hart_pkg::word_t   o_dmem_wdata,
  input  hart_pkg::word_t   i_dmem_rdata,
  output hart_pkg::retire_t o_retire
);

  // pipeline registers, each driven by the stage that owns it
  hart_pkg::if_id_t    if_id;
  hart_pkg::id_ex_t    id_ex;
  hart_pkg::ex_mem_t   ex_mem;
  hart_pkg::mem_wb_t   mem_wb;

  // hazard and redirect levels between stages
  logic                stall;
  logic                flush;
  logic                redirect;
  hart_pkg::word_t     target;
  hart_pkg::reg_addr_t rs1_addr;
  hart_pkg::reg_addr_t rs2_addr;
  hart_pkg::fwd_sel_e  fwd_a_sel;
  hart_pkg::fwd_sel_e  fwd_b_sel;

  // results fed back to execute and to the register file
  hart_pkg::word_t     mem_fwd;
  logic                wb_wen;
  hart_pkg::reg_addr_t wb_addr;
  hart_pkg::word_t     wb_data;

  hart_fetch u_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_stall      (stall),
    .i_flush      (flush),
    .i_redirect   (redirect),
    .i_target     (target),
    .o_imem_raddr (o_imem_raddr),
    .i_imem_rdata (i_imem_rdata),
    .o_if_id      (if_id)
  );

  hart_decode u_decode (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_stall    (stall),
    .i_flush    (flush),
    .i_if_id    (if_id),
    .i_wb_wen   (wb_wen),
    .i_wb_addr  (wb_addr),
    .i_wb_data  (wb_data),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .o_id_ex    (id_ex)
  );

  hart_hazard u_hazard (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_addr  (rs1_addr),
    .i_rs2_addr  (rs2_addr),
    .i_id_ex     (id_ex),
    .i_ex_mem    (ex_mem),
    .i_mem_wb    (mem_wb),
    .i_redirect  (redirect),
    .o_stall     (stall),
    .o_flush     (flush),
    .o_fwd_a_sel (fwd_a_sel),
    .o_fwd_b_sel (fwd_b_sel)
  );

  hart_execute u_execute (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_id_ex     (id_ex),
    .i_fwd_a_sel (fwd_a_sel),
    .i_fwd_b_sel (fwd_b_sel),
    .i_mem_fwd   (mem_fwd),
    .i_wb_fwd    (wb_data),
    .o_redirect  (redirect),
    .o_target    (target),
    .o_ex_mem    (ex_mem)
  );

  hart_memwb u_memwb (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_ex_mem     (ex_mem),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_ren   (o_dmem_ren),
    .o_dmem_wen   (o_dmem_wen),
    .o_dmem_wdata (o_dmem_wdata),
    .i_dmem_rdata (i_dmem_rdata),
    .o_mem_fwd    (mem_fwd),
    .o_mem_wb     (mem_wb),
    .o_wb_wen     (wb_wen),
    .o_wb_addr    (wb_addr),
    .o_wb_data    (wb_data),
    .o_retire     (o_retire)
  );

endmodule

`default_nettype wire

// ==== verif/hart_tb.sv ====
`timescale 1ns/1ns

module hart_tb;

  localparam int clk_period = 8;
  localparam int mem_depth  = 256;
  localparam int pat_depth  = 512;
  // words per expected retire record and per data memory check in the pattern file
  localparam int rec_words  = 6;
  localparam int mem_words  = 3;
  // watchdog budget per expected record, plus margin for reset and drain
  localparam int cycles_per_rec = 20;
  localparam int cycles_margin  = 100;
  // cycles watched after the halt for stray retires
  localparam int drain_cycles   = 20;

  logic              clk;
  logic              rst;
  hart_pkg::word_t   imem_raddr;
  hart_pkg::word_t   imem_rdata;
  hart_pkg::word_t   dmem_addr;
  logic              dmem_ren;
  logic              dmem_wen;
  hart_pkg::word_t   dmem_wdata;
  hart_pkg::word_t   dmem_rdata;
  hart_pkg::retire_t retire;

  hart_pkg::word_t imem [0:mem_depth-1];
  hart_pkg::word_t dmem [0:mem_depth-1];
  logic [31:0]     pat  [0:pat_depth-1];

  int   n_prog;
  int   n_rec;
  int   n_mem;
  int   rec_base;
  int   mem_base;
  int   rec_idx;
  int   cur_test;
  int   errors;
  int   checks;
  int   test_errors;
  int   test_recs;
  int   tests_done;
  int   n_reads;
  int   n_writes;
  logic pat_loaded;

  hart i_hart (
    .i_clk        (clk),
    .i_rst        (rst),
    .o_imem_raddr (imem_raddr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_ren   (dmem_ren),
    .o_dmem_wen   (dmem_wen),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata),
    .o_retire     (retire)
  );

  // both memories answer reads in the same cycle and are word addressed
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  // a store lands at the edge that ends its memory stage cycle
  always @(posedge clk) begin
    if (dmem_wen) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // the budget depends on the record count, so wait until the file is read
  initial begin
    int limit;
    wait (pat_loaded === 1'b1);
    limit = (cycles_per_rec * n_rec + cycles_margin) * clk_period;
    #(limit);
    $display("error: run timed out after %0t ns with %0d of %0d records retired",
             $time, rec_idx, n_rec);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "alu and upper immediates";
      2:       return "forwarding at distance 1 to 3";
      3:       return "store then load";
      4:       return "branches and jumps";
      5:       return "trap and halt";
      default: return "unnamed";
    endcase
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // fields are checked in the order of the retire record
  task automatic check_retire(input int idx);
    int          base;
    logic [31:0] flags;
    base  = rec_base + rec_words * idx;
    flags = pat[base + 5];
    compare_word("retire.inst", retire.inst, pat[base + 2]);
    compare_word("retire.trap", {31'b0, retire.trap}, {31'b0, flags[0]});
    compare_word("retire.halt", {31'b0, retire.halt}, {31'b0, flags[1]});
    compare_word("retire.pc", retire.pc, pat[base]);
    compare_word("retire.next_pc", retire.next_pc, pat[base + 1]);
    compare_word("retire.rd_waddr", {27'b0, retire.rd_waddr}, pat[base + 3]);
    compare_word("retire.rd_wdata", retire.rd_wdata, pat[base + 4]);
  endtask

  // the data port is sampled once per cycle while the core runs
  task automatic count_dmem_access();
    if (dmem_ren === 1'b1) begin
      n_reads++;
    end
    if (dmem_wen === 1'b1) begin
      n_writes++;
    end
  endtask

  // each lw or sw that retires without a trap uses the data port for one cycle
  function automatic int count_retired_opcode(input logic [6:0] op);
    int n;
    int base;
    n = 0;
    for (int r = 0; r < n_rec; r++) begin
      base = rec_base + rec_words * r;
      if (pat[base + 2][6:0] == op && pat[base + 5][0] == 1'b0) begin
        n++;
      end
    end
    return n;
  endfunction

  // stored words that belong to one test are checked once its records are done
  task automatic check_memory(input int id);
    int          base;
    logic [31:0] addr;
    for (int m = 0; m < n_mem; m++) begin
      base = mem_base + mem_words * m;
      if (pat[base] == id) begin
        addr = pat[base + 1];
        compare_word($sformatf("dmem[%h]", addr), dmem[addr[9:2]], pat[base + 2]);
      end
    end
  endtask

  task automatic close_test(input int id);
    check_memory(id);
    $display("test %0d %s: %0d records, %0d errors", id, test_name(id), test_recs,
             test_errors);
    tests_done++;
    test_recs   = 0;
    test_errors = 0;
  endtask

  initial begin
    int test_id;
    rst         = 1'b1;
    pat_loaded  = 1'b0;
    rec_idx     = 0;
    cur_test    = 0;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    test_recs   = 0;
    tests_done  = 0;
    n_reads     = 0;
    n_writes    = 0;
    for (int a = 0; a < mem_depth; a++) begin
      imem[a] = '0;
      dmem[a] = '0;
    end

    // counts first, then program words, records and data checks
    $readmemh("verif/hart_patterns.hex", pat);
    n_prog   = pat[0];
    n_rec    = pat[1];
    n_mem    = pat[2];
    rec_base = 3 + n_prog;
    mem_base = rec_base + rec_words * n_rec;
    for (int a = 0; a < n_prog; a++) begin
      imem[a] = pat[3 + a];
    end
    pat_loaded = 1'b1;

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // sample mid cycle where the retire record is settled
    while (rec_idx < n_rec) begin
      @(negedge clk);
      count_dmem_access();
      if (retire.valid === 1'b1) begin
        test_id = int'(pat[rec_base + rec_words * rec_idx + 5][11:8]);
        if (test_id != cur_test) begin
          if (cur_test != 0) begin
            close_test(cur_test);
          end
          cur_test = test_id;
        end
        check_retire(rec_idx);
        test_recs++;
        rec_idx++;
      end
    end

    // ebreak is the last record and nothing may retire behind it
    repeat (drain_cycles) begin
      @(negedge clk);
      count_dmem_access();
      if (retire.valid === 1'b1) begin
        errors++;
        test_errors++;
        $display("error at %0t ns: an instruction at pc %h retired after the halt",
                 $time, retire.pc);
      end
    end
    compare_word("o_dmem_ren cycles", n_reads, count_retired_opcode(7'b0000011));
    compare_word("o_dmem_wen cycles", n_writes, count_retired_opcode(7'b0100011));
    close_test(cur_test);

    $display("done: %0d tests, %0d records, %0d checks, %0d errors", tests_done, rec_idx,
             checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/hart_patterns.hex ====
// head: program word count, record count, data check count; then program words from pc 0
// records: pc next_pc inst rd rd_wdata flags (test id in 11:8, halt bit 1, trap bit 0)
// data checks at the end: test id, byte address, expected word
0000003d 00000032 00000003
123450b7 ff900113 00500193 00001217 003102b3 40218333 003193b3 00312433 // 0x00
003134b3 0020c533 003155b3 40315633 0030e6b3 00117733 ffa12793 fff1b813 // 0x20
7ff1c893 1001e913 0f017993 01c19a13 01c15a93 40115b13 06400b93 017b8c33 // 0x40
00100c93 417c0d33 002c8c93 004c8c93 01ac8db3 04102023 04002e03 001e0e93 // 0x60
05d02223 04402f03 05eba423 00311663 001f8f93 001f8f93 00310663 00314663 // 0x80
001f8f93 001f8f93 00315463 0021e663 001f8f93 001f8f93 0021f463 00c000ef // 0xa0
001f8f93 001f8f93 0d800293 001283e7 001f8f93 001f8f93 00708433 000f84b3 // 0xc0
0000018b 00018513 00000073 00100073 00100593                            // 0xe0
00000000 00000004 123450b7 01 12345000 100
00000004 00000008 ff900113 02 fffffff9 100
00000008 0000000c 00500193 03 00000005 100
0000000c 00000010 00001217 04 0000100c 100
00000010 00000014 003102b3 05 fffffffe 100
00000014 00000018 40218333 06 0000000c 100
00000018 0000001c 003193b3 07 000000a0 100
0000001c 00000020 00312433 08 00000001 100
00000020 00000024 003134b3 09 00000000 100
00000024 00000028 0020c533 0a edcbaff9 100
00000028 0000002c 003155b3 0b 07ffffff 100
0000002c 00000030 40315633 0c ffffffff 100
00000030 00000034 0030e6b3 0d 12345005 100
00000034 00000038 00117733 0e 12345000 100
00000038 0000003c ffa12793 0f 00000001 100
0000003c 00000040 fff1b813 10 00000001 100
00000040 00000044 7ff1c893 11 000007fa 100
00000044 00000048 1001e913 12 00000105 100
00000048 0000004c 0f017993 13 000000f0 100
0000004c 00000050 01c19a13 14 50000000 100
00000050 00000054 01c15a93 15 0000000f 100
00000054 00000058 40115b13 16 fffffffc 100
00000058 0000005c 06400b93 17 00000064 200
0000005c 00000060 017b8c33 18 000000c8 200
00000060 00000064 00100c93 19 00000001 200
00000064 00000068 417c0d33 1a 00000064 200
00000068 0000006c 002c8c93 19 00000003 200
0000006c 00000070 004c8c93 19 00000007 200
00000070 00000074 01ac8db3 1b 0000006b 200
00000074 00000078 04102023 00 00000000 300
00000078 0000007c 04002e03 1c 12345000 300
0000007c 00000080 001e0e93 1d 12345001 300
00000080 00000084 05d02223 00 00000000 300
00000084 00000088 04402f03 1e 12345001 300
00000088 0000008c 05eba423 00 00000000 300
0000008c 00000098 00311663 00 00000000 400
00000098 0000009c 00310663 00 00000000 400
0000009c 000000a8 00314663 00 00000000 400
000000a8 000000ac 00315463 00 00000000 400
000000ac 000000b8 0021e663 00 00000000 400
000000b8 000000bc 0021f463 00 00000000 400
000000bc 000000c8 00c000ef 01 000000c0 400
000000c8 000000cc 0d800293 05 000000d8 400
000000cc 000000d8 001283e7 07 000000d0 400
000000d8 000000dc 00708433 08 00000190 400
000000dc 000000e0 000f84b3 09 00000000 400
000000e0 000000e4 0000018b 00 00000000 501
000000e4 000000e8 00018513 0a 00000005 500
000000e8 000000ec 00000073 00 00000000 501
000000ec 000000f0 00100073 00 00000000 502
00000003 00000040 12345000
00000003 00000044 12345001
00000003 000000ac 12345001

// ==== hart.f ====
logic/hart_pkg.sv
logic/hart_fetch.sv
logic/hart_regfile.sv
logic/hart_decode.sv
logic/hart_hazard.sv
logic/hart_execute.sv
logic/hart_memwb.sv
logic/hart.sv
verif/hart_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the hart testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module hart_tb -Mdir obj_dir -f hart.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vhart_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
